/* Bender.yml */
package:
  name: spi_solo

sources:
  - files:
      - design/spi_solo_pkg.sv
      - design/spi_byte_fifo.sv
      - design/spi_phase_gen.sv
      - design/spi_cmd_latch.sv
      - design/spi_bus_fsm.sv
      - design/spi_rx_capture.sv
      - design/spi_solo_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/spi_solo_tb.sv

/* design/spi_bus_fsm.sv */
////////////////////////////////////////
// State changes only on sck_fall, so every state is whole SCK periods
// Bus pins are registered one clock behind the state
////////////////////////////////////////
module spi_bus_fsm (
  input  logic                    i_ext_spi_clk_x,
  input  logic                    i_srst,
  input  logic                    start_i,
  input  spi_solo_pkg::spi_cmd_t  cmd_i,
  input  logic                    sck_lvl_i,
  input  logic                    sck_rise_i,
  input  logic                    sck_fall_i,
  input  spi_solo_pkg::byte_t     tx_data_i,
  input  logic                    tx_empty_i,
  output logic                    tx_pop_o,
  output logic                    rx_sample_o,
  output logic                    rx_last_o,
  output spi_solo_pkg::spi_pins_t spi_o,
  output logic                    idle_o
);
  import spi_solo_pkg::*;

  localparam logic [TIMER_W-1:0] SS_LAST = TIMER_W'(SS_CYC - 1);  // Last framing period

  spi_state_e         state_q;
  spi_state_e         state_d;
  spi_state_e         post_tx_st;   // Where TX hands over
  logic [TIMER_W-1:0] timer_q;      // Bit timer counting SCK periods in a state
  logic [TIMER_W-1:0] tx_last_bit;
  logic [TIMER_W-1:0] rx_last_bit;
  logic [TIMER_W-1:0] wait_last;
  logic               pend_q;       // Start waiting for the next sck_fall
  logic               go_now;
  logic               byte_edge;    // Slot boundary where a TX byte is due
  logic               tx_have_q;    // Current TX slot got a byte
  logic               sck_run;
  spi_pins_t          pins_d;
  spi_pins_t          spi_q;

  ////////////////////////////////////////
  // Phase limits from the latched command
  ////////////////////////////////////////
  assign tx_last_bit = TIMER_W'({cmd_i.tx_len, 3'b000}) - 1'b1;
  assign rx_last_bit = TIMER_W'({cmd_i.rx_len, 3'b000}) - 1'b1;
  assign wait_last   = TIMER_W'(cmd_i.wait_cyc) - 1'b1;

  assign go_now = start_i | pend_q;
  assign idle_o = (state_q == IDLE) & ~go_now;  // Low as soon as start arrives

  always_comb begin
    if (cmd_i.wait_cyc != '0) begin
      post_tx_st = WAIT;
    end else if (cmd_i.rx_len != '0) begin
      post_tx_st = RX;
    end else begin
      post_tx_st = STOP_S;
    end
  end

  // Next state taken on sck_fall only
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (go_now) state_d = START_D;
      START_D: if (timer_q == SS_LAST) state_d = START_S;
      START_S: begin
        if (timer_q == SS_LAST) begin
          state_d = (cmd_i.tx_len != '0) ? TX : post_tx_st;  // Empty TX skipped
        end
      end
      TX:      if (timer_q == tx_last_bit) state_d = post_tx_st;
      WAIT: begin
        if (timer_q == wait_last) begin
          state_d = (cmd_i.rx_len != '0) ? RX : STOP_S;
        end
      end
      RX:      if (timer_q == rx_last_bit) state_d = STOP_S;
      STOP_S:  if (timer_q == SS_LAST) state_d = STOP_D;
      STOP_D:  if (timer_q == SS_LAST) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) begin
      state_q <= IDLE;
      timer_q <= '0;
      pend_q  <= 1'b0;
    end else begin
      pend_q <= go_now & ~sck_fall_i;  // Cleared when IDLE is left
      if (sck_fall_i) begin
        state_q <= state_d;
        if ((state_d != state_q) || (state_q == IDLE)) begin
          timer_q <= '0;               // Fresh count per state
        end else begin
          timer_q <= timer_q + 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////
  // TX byte fetch
  ////////////////////////////////////////
  // FIFO data lands on the same edge as the state or slot change
  assign byte_edge = sck_fall_i & (((state_q == START_S) && (state_d == TX)) ||
                     ((state_q == TX) && (timer_q[2:0] == 3'd7) &&
                      (timer_q != tx_last_bit)));
  assign tx_pop_o  = byte_edge & ~tx_empty_i;

  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) begin
      tx_have_q <= 1'b0;
    end else if (byte_edge) begin
      tx_have_q <= ~tx_empty_i;  // Underflow slot sends zeros
    end
  end

  // RX strobes for the capture block
  assign rx_sample_o = sck_rise_i & (state_q == RX);
  assign rx_last_o   = (state_q == RX) & (timer_q[2:0] == 3'd7);

  ////////////////////////////////////////
  // Pins
  ////////////////////////////////////////
  assign sck_run = (state_q == TX) || (state_q == WAIT) || (state_q == RX);

  always_comb begin
    pins_d.sck  = sck_lvl_i & sck_run;  // One pulse per period while running
    pins_d.csn  = (state_q == IDLE) || (state_q == START_D) || (state_q == STOP_D);
    pins_d.copi = (state_q == TX) & tx_have_q & tx_data_i[3'd7 - timer_q[2:0]];  // MSB first
  end

  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) begin
      spi_q <= '{sck: 1'b0, csn: 1'b1, copi: 1'b0};
    end else begin
      spi_q <= pins_d;
    end
  end

  assign spi_o = spi_q;

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////
  a_idle_deselect: assert property (@(posedge i_ext_spi_clk_x) disable iff (i_srst)
    (state_q == IDLE) |-> spi_o.csn);

  a_pop_nonempty: assert property (@(posedge i_ext_spi_clk_x) disable iff (i_srst)
    tx_pop_o |-> !tx_empty_i);

endmodule : spi_bus_fsm

/* design/spi_byte_fifo.sv */
////////////////////////////////////////
// FIFO_DEPTH must be a power of two
// Read data appears one clock after pop
////////////////////////////////////////
module spi_byte_fifo #(
  parameter int FIFO_DEPTH = 512
) (
  input  logic                i_ext_spi_clk_x,
  input  logic                i_srst,
  input  logic                push_i,
  input  spi_solo_pkg::byte_t data_i,
  input  logic                pop_i,
  output spi_solo_pkg::byte_t data_o,
  output logic                valid_o,
  output logic                full_o,
  output logic                empty_o
);
  import spi_solo_pkg::*;

  localparam int AW = $clog2(FIFO_DEPTH);

  byte_t         mem [FIFO_DEPTH];  // Storage array
  logic [AW-1:0] wr_ptr_q;          // Next write slot
  logic [AW-1:0] rd_ptr_q;          // Next read slot
  logic [AW:0]   count_q;           // Occupancy, one bit wider than pointers
  logic          push_ok;
  logic          pop_ok;

  assign full_o  = (count_q == (AW+1)'(FIFO_DEPTH));
  assign empty_o = (count_q == '0);
  assign push_ok = push_i & ~full_o;   // Push into a full FIFO is dropped
  assign pop_ok  = pop_i & ~empty_o;   // Pop of an empty FIFO is ignored

  // Pointers and occupancy
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      valid_o  <= 1'b0;
    end else begin
      valid_o <= pop_ok;
      if (push_ok) wr_ptr_q <= wr_ptr_q + 1'b1;  // Wraps at depth
      if (pop_ok)  rd_ptr_q <= rd_ptr_q + 1'b1;
      if (push_ok && !pop_ok) begin
        count_q <= count_q + 1'b1;
      end else if (pop_ok && !push_ok) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Array write and registered read
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (push_ok) mem[wr_ptr_q] <= data_i;
    if (pop_ok)  data_o        <= mem[rd_ptr_q];  // Holds until next pop
  end

  a_count_bound: assert property (@(posedge i_ext_spi_clk_x) disable iff (i_srst)
    count_q <= (AW+1)'(FIFO_DEPTH));

endmodule : spi_byte_fifo

/* design/spi_cmd_latch.sv */
////////////////////////////////////////
// Go is taken only while the master is idle
// Held command is stable for the whole transaction
////////////////////////////////////////
module spi_cmd_latch (
  input  logic                   i_ext_spi_clk_x,
  input  logic                   i_srst,
  input  logic                   go_i,
  input  spi_solo_pkg::spi_cmd_t cmd_i,
  input  logic                   idle_i,
  output spi_solo_pkg::spi_cmd_t cmd_o,
  output logic                   start_o
);
  import spi_solo_pkg::*;

  spi_cmd_t cmd_q;   // Command of the running transaction
  logic     accept;  // Go seen while idle

  assign accept = go_i & idle_i;
  assign cmd_o  = cmd_q;

  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) begin
      cmd_q   <= '0;
      start_o <= 1'b0;
    end else begin
      start_o <= accept;  // One clock after the accepted go
      if (accept) begin
        cmd_q <= cmd_i;
      end
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////
  // A transaction moves at least one byte
  a_len_nonzero: assert property (@(posedge i_ext_spi_clk_x) disable iff (i_srst)
    accept |-> (cmd_i.tx_len != '0) || (cmd_i.rx_len != '0));

endmodule : spi_cmd_latch

/* design/spi_phase_gen.sv */
////////////////////////////////////////
// CLK_RATIO must be a multiple of 4 and at least 8
////////////////////////////////////////
module spi_phase_gen #(
  parameter int CLK_RATIO = 32
) (
  input  logic i_ext_spi_clk_x,
  input  logic i_srst,
  output logic sck_lvl_o,
  output logic sck_rise_o,
  output logic sck_fall_o
);
  localparam int CW   = $clog2(CLK_RATIO);
  localparam int HALF = CLK_RATIO / 2;

  logic [CW-1:0] cnt_q;  // Position inside one SCK period

  // Free-running phase counter
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) begin
      cnt_q <= '0;
    end else if (cnt_q == CW'(CLK_RATIO - 1)) begin
      cnt_q <= '0;  // Period wrap
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Low first half, high second half
  assign sck_fall_o = (cnt_q == '0);        // Period start where states change
  assign sck_rise_o = (cnt_q == CW'(HALF)); // Mid period where data is sampled
  assign sck_lvl_o  = (cnt_q >= CW'(HALF));

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////
  a_ratio_rule: assert property (@(posedge i_ext_spi_clk_x)
    (CLK_RATIO % 4 == 0) && (CLK_RATIO >= 8));

endmodule : spi_phase_gen

/* design/spi_rx_capture.sv */
////////////////////////////////////////
// CIPO passes a two-flop synchronizer
// Strobes are delayed two clocks to match it
////////////////////////////////////////
module spi_rx_capture (
  input  logic                i_ext_spi_clk_x,
  input  logic                i_srst,
  input  logic                cipo_i,
  input  logic                rx_sample_i,
  input  logic                rx_last_i,
  output logic                rx_push_o,
  output spi_solo_pkg::byte_t rx_byte_o
);
  import spi_solo_pkg::*;

  logic [1:0] cipo_sync_q;   // [1] is the synchronized bit
  logic [1:0] sample_dly_q;  // Sample strobe, aligned to cipo_sync_q[1]
  logic [1:0] last_dly_q;    // Last-bit flag, same alignment
  byte_t      shift_q;       // Bits gathered so far, MSB first
  logic       bit_now;

  assign bit_now = cipo_sync_q[1];

  // Synchronizer and matching strobe delay
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) begin
      cipo_sync_q  <= '0;
      sample_dly_q <= '0;
      last_dly_q   <= '0;
    end else begin
      cipo_sync_q  <= {cipo_sync_q[0], cipo_i};
      sample_dly_q <= {sample_dly_q[0], rx_sample_i};
      last_dly_q   <= {last_dly_q[0], rx_sample_i & rx_last_i};
    end
  end

  // Shift path
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (sample_dly_q[1]) begin
      shift_q <= {shift_q[6:0], bit_now};
    end
  end

  // Completed byte includes the bit shifted on this clock
  assign rx_push_o = sample_dly_q[1] & last_dly_q[1];
  assign rx_byte_o = {shift_q[6:0], bit_now};  // FIFO drops it when full

endmodule : spi_rx_capture

/* design/spi_solo_pkg.sv */
////////////////////////////////////////
// Shared widths and types of the SPI master
// Lengths are limited to 1023 bytes per phase
////////////////////////////////////////
package spi_solo_pkg;

  ////////////////////////////////////////
  // Widths and framing constants
  ////////////////////////////////////////
  typedef logic [7:0] byte_t;  // One data byte

  localparam int LEN_W   = 10;         // Byte-count field, 0 to 1023
  localparam int WAIT_W  = 5;          // Wait field, up to 31 SCK periods
  localparam int TIMER_W = LEN_W + 3;  // Bit timer holds 8 * max length
  localparam int SS_CYC  = 4;          // SCK periods per framing state

  ////////////////////////////////////////
  // Transaction state
  ////////////////////////////////////////
  typedef enum logic [2:0] {
    IDLE,     // Bus parked, csn high
    START_D,  // Deselect lead-in
    START_S,  // Chip-select setup
    TX,       // Shift out TX bytes
    WAIT,     // Dummy clocks between TX and RX
    RX,       // Shift in RX bytes
    STOP_S,   // Chip-select hold
    STOP_D    // Deselect tail
  } spi_state_e;

  // Command as latched on go
  typedef struct packed {
    logic [LEN_W-1:0]  tx_len;    // Bytes to send
    logic [LEN_W-1:0]  rx_len;    // Bytes to receive
    logic [WAIT_W-1:0] wait_cyc;  // Idle SCK periods after TX
  } spi_cmd_t;

  // Bus pins driven by the master
  typedef struct packed {
    logic sck;   // Mode 0, idles low
    logic csn;   // Active low select
    logic copi;  // Controller out
  } spi_pins_t;

endpackage : spi_solo_pkg

/* design/spi_solo_top.sv */
////////////////////////////////////////
// Go is ignored unless spi_idle_o is high
// CLK_RATIO multiple of 4, FIFO_DEPTH power of two
////////////////////////////////////////
module spi_solo_top #(
  parameter int CLK_RATIO  = 32,
  parameter int FIFO_DEPTH = 512
) (
  input  logic                    i_ext_spi_clk_x,
  input  logic                    i_srst,
  input  logic                    go_i,
  input  spi_solo_pkg::spi_cmd_t  cmd_i,
  input  logic                    tx_enqueue_i,
  input  spi_solo_pkg::byte_t     tx_data_i,
  output logic                    tx_ready_o,
  input  logic                    rx_dequeue_i,
  output spi_solo_pkg::byte_t     rx_data_o,
  output logic                    rx_valid_o,
  output logic                    rx_avail_o,
  output logic                    spi_idle_o,
  output spi_solo_pkg::spi_pins_t spi_o,
  input  logic                    cipo_i
);
  import spi_solo_pkg::*;

  spi_cmd_t cmd;
  logic     start;
  logic     sck_lvl;
  logic     sck_rise;
  logic     sck_fall;
  logic     tx_pop;
  logic     tx_full;
  logic     tx_empty;
  byte_t    tx_data;
  logic     rx_sample;
  logic     rx_last;
  logic     rx_push;
  byte_t    rx_byte;
  logic     rx_empty;

  assign tx_ready_o = ~tx_full;
  assign rx_avail_o = ~rx_empty;

  ////////////////////////////////////////
  // Byte FIFOs
  ////////////////////////////////////////
  spi_byte_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_tx_fifo (
    .i_ext_spi_clk_x, .i_srst,
    .push_i(tx_enqueue_i), .data_i(tx_data_i), .pop_i(tx_pop),
    .data_o(tx_data), .valid_o(), .full_o(tx_full), .empty_o(tx_empty)
  );

  spi_byte_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_rx_fifo (
    .i_ext_spi_clk_x, .i_srst,
    .push_i(rx_push), .data_i(rx_byte), .pop_i(rx_dequeue_i),
    .data_o(rx_data_o), .valid_o(rx_valid_o), .full_o(), .empty_o(rx_empty)
  );

  ////////////////////////////////////////
  // Control path
  ////////////////////////////////////////
  spi_cmd_latch u_cmd_latch (
    .i_ext_spi_clk_x, .i_srst, .go_i, .cmd_i,
    .idle_i(spi_idle_o), .cmd_o(cmd), .start_o(start)
  );

  spi_phase_gen #(.CLK_RATIO(CLK_RATIO)) u_phase_gen (
    .i_ext_spi_clk_x, .i_srst,
    .sck_lvl_o(sck_lvl), .sck_rise_o(sck_rise), .sck_fall_o(sck_fall)
  );

  spi_bus_fsm u_bus_fsm (
    .i_ext_spi_clk_x, .i_srst, .start_i(start), .cmd_i(cmd),
    .sck_lvl_i(sck_lvl), .sck_rise_i(sck_rise), .sck_fall_i(sck_fall),
    .tx_data_i(tx_data), .tx_empty_i(tx_empty), .tx_pop_o(tx_pop),
    .rx_sample_o(rx_sample), .rx_last_o(rx_last), .spi_o, .idle_o(spi_idle_o)
  );

  spi_rx_capture u_rx_capture (
    .i_ext_spi_clk_x, .i_srst, .cipo_i,
    .rx_sample_i(rx_sample), .rx_last_i(rx_last),
    .rx_push_o(rx_push), .rx_byte_o(rx_byte)
  );

endmodule : spi_solo_top

/* spi_solo_top.f */
+incdir+tb
design/spi_solo_pkg.sv
design/spi_byte_fifo.sv
design/spi_phase_gen.sv
design/spi_cmd_latch.sv
design/spi_bus_fsm.sv
design/spi_rx_capture.sv
design/spi_solo_top.sv
tb/spi_solo_tb.sv

/* tb/spi_solo_tests.svh */
////////////////////////////////////////
// Directed tests included inside the testbench module
// Each starts with the master idle on a falling clock edge
////////////////////////////////////////
`ifndef SPI_SOLO_TESTS_SVH
`define SPI_SOLO_TESTS_SVH

// Reset values and then one frame of zeros from an empty TX FIFO
task automatic test_reset_idle();
  int n;
  check_eq("reset_idle idle", 1, spi_idle);
  check_eq("reset_idle csn", 1, csn);
  check_eq("reset_idle sck", 0, sck);
  check_eq("reset_idle tx_ready", 1, tx_ready);
  check_eq("reset_idle rx_avail", 0, rx_avail);
  clear_model(0);
  issue_go(build_cmd(1, 0, 0));
  n = 0;
  // Phase alignment, lead-in and pin register
  while (csn && (n < (SS_CYC + 1) * CLK_RATIO + 2)) begin
    @(negedge clk);
    n++;
  end
  check_eq("reset_idle csn_low", 0, csn);
  wait_idle("reset_idle", 8);
  check_eq("reset_idle pulses", 8, sck_pulses);
  check_eq("reset_idle zero byte", 8'h00, copi_byte(0));
endtask

task automatic test_write_only();
  byte_t sent [3];
  clear_model(0);
  for (int i = 0; i < 3; i++) begin
    sent[i] = rand_byte();
    push_tx(sent[i]);
  end
  issue_go(build_cmd(3, 0, 0));
  wait_idle("write_only", 24);
  check_eq("write_only pulses", 24, sck_pulses);
  for (int i = 0; i < 3; i++) begin
    check_eq($sformatf("write_only byte %0d", i), sent[i], copi_byte(i));
  end
  repeat (CLK_RATIO) @(negedge clk);  // Master stays parked after the frame
  check_eq("write_only idle", 1, spi_idle);
  check_eq("write_only csn", 1, csn);
endtask

task automatic test_write_wait_read();
  byte_t sent;
  byte_t resp [2];
  byte_t got;
  clear_model(8 + 5);  // Response follows the TX byte and the wait clocks
  sent = rand_byte();
  push_tx(sent);
  for (int i = 0; i < 2; i++) begin
    resp[i] = rand_byte();
    resp_bytes.push_back(resp[i]);
  end
  issue_go(build_cmd(1, 2, 5));
  wait_idle("write_wait_read", 8 + 5 + 16);
  check_eq("write_wait_read pulses", 8 + 5 + 16, sck_pulses);
  check_eq("write_wait_read tx byte", sent, copi_byte(0));
  for (int i = 0; i < 2; i++) begin
    pop_rx(got, "write_wait_read");
    check_eq($sformatf("write_wait_read rx byte %0d", i), resp[i], got);
  end
  check_eq("write_wait_read drained", 0, rx_avail);
endtask

// Second slot has no byte so COPI stays low for it
task automatic test_tx_underflow();
  byte_t sent;
  clear_model(0);
  sent = rand_byte();
  push_tx(sent);
  issue_go(build_cmd(2, 0, 0));
  wait_idle("tx_underflow", 16);
  check_eq("tx_underflow pulses", 16, sck_pulses);
  check_eq("tx_underflow byte 0", sent, copi_byte(0));
  check_eq("tx_underflow byte 1", 8'h00, copi_byte(1));
  check_eq("tx_underflow tx_ready", 1, tx_ready);
endtask

task automatic test_go_while_busy();
  byte_t sent [2];
  int    n;
  clear_model(0);
  for (int i = 0; i < 2; i++) begin
    sent[i] = rand_byte();
    push_tx(sent[i]);
  end
  issue_go(build_cmd(2, 0, 0));
  n = 0;
  while (csn && (n < (SS_CYC + 1) * CLK_RATIO + 2)) begin
    @(negedge clk);
    n++;
  end
  check_eq("go_while_busy csn_low", 0, csn);
  issue_go(build_cmd(1, 3, 7));  // Dropped while the master is busy
  wait_idle("go_while_busy", 16);
  check_eq("go_while_busy pulses", 16, sck_pulses);
  check_eq("go_while_busy byte 0", sent[0], copi_byte(0));
  check_eq("go_while_busy byte 1", sent[1], copi_byte(1));
  repeat (10 * CLK_RATIO) @(negedge clk);  // A second frame would select here
  check_eq("go_while_busy csn_falls", 1, csn_falls);
  check_eq("go_while_busy quiet", 16, sck_pulses);
  check_eq("go_while_busy idle", 1, spi_idle);
  check_eq("go_while_busy rx_avail", 0, rx_avail);
endtask

`endif

/* tb/spi_solo_tb.sv */
////////////////////////////////////////
// Mode 0 peripheral model with CLK_RATIO 8 and FIFO_DEPTH 16
// CIPO data starts after resp_start SCK pulses of a frame
////////////////////////////////////////
module spi_solo_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import spi_solo_pkg::*;

  localparam int CLK_RATIO   = 8;
  localparam int FIFO_DEPTH  = 16;
  localparam int TOTAL_BITS  = 8 + 24 + 29 + 16 + 16;  // SCK pulses of all frames
  localparam int FRAME_PER   = 4 * SS_CYC + 1;         // Framing plus phase alignment
  localparam int WATCHDOG_NS = (TOTAL_BITS + 5 * FRAME_PER + 20) * CLK_RATIO * 10 + 2000;

  logic        clk = 1'b0;
  logic        srst;
  logic        go;
  spi_cmd_t    cmd;
  logic        tx_enq;
  byte_t       tx_data;
  logic        tx_ready;
  logic        rx_deq;
  byte_t       rx_data;
  logic        rx_valid;
  logic        rx_avail;
  logic        spi_idle;
  spi_pins_t   spi_pins;
  logic        sck;
  logic        csn;
  logic        copi;
  logic        cipo_q = 1'b0;  // Peripheral output
  byte_t       resp_bytes[$];  // Bytes the peripheral returns
  logic        copi_bits[$];   // COPI seen at every SCK rise
  int          resp_start;     // Pulses before the first response bit
  int          sck_pulses;
  int          csn_falls;
  int          err_cnt;
  logic [31:0] rng_q;

  always #5 clk = ~clk;  // 10 ns period

  assign sck  = spi_pins.sck;
  assign csn  = spi_pins.csn;
  assign copi = spi_pins.copi;

  spi_solo_top #(.CLK_RATIO(CLK_RATIO), .FIFO_DEPTH(FIFO_DEPTH)) spi_solo_top_i (
    .i_ext_spi_clk_x(clk), .i_srst(srst),
    .go_i(go), .cmd_i(cmd),
    .tx_enqueue_i(tx_enq), .tx_data_i(tx_data), .tx_ready_o(tx_ready),
    .rx_dequeue_i(rx_deq), .rx_data_o(rx_data), .rx_valid_o(rx_valid),
    .rx_avail_o(rx_avail), .spi_idle_o(spi_idle),
    .spi_o(spi_pins), .cipo_i(cipo_q)
  );

  ////////////////////////////////////////
  // Peripheral model
  ////////////////////////////////////////
  function automatic logic resp_bit_at(input int pulses);
    int b;
    b = pulses - resp_start;  // Bit index in the response stream
    if ((b < 0) || ((b / 8) >= resp_bytes.size())) begin
      return 1'b0;            // Zero when nothing is queued
    end
    return resp_bytes[b / 8][7 - (b % 8)];
  endfunction

  always @(posedge sck) begin
    if (!csn) begin
      sck_pulses = sck_pulses + 1;
      copi_bits.push_back(copi);  // Mode 0 sample on rise
    end
  end

  // Next bit goes out after each fall and at select
  always @(negedge sck or negedge csn) begin
    @(negedge clk);  // Presented to the DUT on a falling clock edge
    cipo_q = csn ? 1'b0 : resp_bit_at(sck_pulses);
  end

  always @(negedge csn) csn_falls = csn_falls + 1;

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////
  task automatic fail_run(input string why);
    err_cnt++;
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "Simulation stopped at first failure");
  endtask

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      fail_run($sformatf("ERROR %s: expected 0x%0h, actual 0x%0h", name, exp, act));
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic byte_t rand_byte();
    rng_q = xorshift32(rng_q);
    return rng_q[7:0];
  endfunction

  function automatic spi_cmd_t build_cmd(input int tx, input int rx, input int w);
    spi_cmd_t c;
    c.tx_len   = LEN_W'(tx);
    c.rx_len   = LEN_W'(rx);
    c.wait_cyc = WAIT_W'(w);
    return c;
  endfunction

  // Byte k of the COPI stream MSB first with missing bits read as zero
  function automatic byte_t copi_byte(input int k);
    byte_t v;
    v = '0;
    for (int i = 0; i < 8; i++) begin
      if ((8 * k + i) < copi_bits.size()) begin
        v = {v[6:0], copi_bits[8 * k + i]};
      end else begin
        v = {v[6:0], 1'b0};
      end
    end
    return v;
  endfunction

  // Bus tasks start and end on a falling clock edge
  task automatic push_tx(input byte_t b);
    tx_data = b;
    tx_enq  = 1'b1;
    @(negedge clk);
    tx_enq  = 1'b0;
  endtask

  task automatic issue_go(input spi_cmd_t c);
    cmd = c;
    go  = 1'b1;
    @(negedge clk);
    go  = 1'b0;
  endtask

  task automatic pop_rx(output byte_t b, input string name);
    check_eq({name, " rx_avail"}, 1, rx_avail);
    rx_deq = 1'b1;
    @(negedge clk);
    rx_deq = 1'b0;
    check_eq({name, " rx_valid"}, 1, rx_valid);  // One clock after the pop
    b = rx_data;
  endtask

  // Limit is the whole frame for the given bit count
  task automatic wait_idle(input string name, input int bits);
    int limit;
    int n;
    limit = (bits + 4 * SS_CYC + 2) * CLK_RATIO;
    n = 0;
    while (!spi_idle) begin
      @(negedge clk);
      n++;
      if (n > limit) begin
        fail_run($sformatf("%s: master did not return to idle in time", name));
      end
    end
  endtask

  task automatic clear_model(input int start);
    resp_bytes.delete();
    copi_bits.delete();
    sck_pulses = 0;
    csn_falls  = 0;
    resp_start = start;
  endtask

  `include "spi_solo_tests.svh"

  ////////////////////////////////////////
  // Watchdog and test sequence
  ////////////////////////////////////////
  initial begin
    #(WATCHDOG_NS);
    fail_run("Watchdog expired, the tests took longer than their frames allow");
  end

  initial begin
    srst    = 1'b1;
    go      = 1'b0;
    cmd     = '0;
    tx_enq  = 1'b0;
    tx_data = '0;
    rx_deq  = 1'b0;
    rng_q   = 32'h5c55;
    err_cnt = 0;
    clear_model(0);
    repeat (8) @(negedge clk);  // Reset held for 8 cycles
    srst = 1'b0;
    @(negedge clk);
    test_reset_idle();
    test_write_only();
    test_write_wait_read();
    test_tx_underflow();
    test_go_while_busy();
    if (err_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule : spi_solo_tb
